/* hw/ps2_config.svh */
`ifndef PS2_CONFIG_SVH
`define PS2_CONFIG_SVH

// Scan code set 2 prefix bytes
`define PS2_EXT_CODE 8'hE0
`define PS2_BREAK_CODE 8'hF0

// Cycles of clk without a PS/2 clock falling edge before a partial frame is dropped
`define PS2_RX_TIMEOUT 2000

// Camera speed index after reset
`define PS2_SPEED_RESET 0

`endif

/* hw/ps2_pkg.sv */
package ps2_pkg;

  // One key with a single-cycle pulse per bit
  typedef struct packed {
    logic released;
    logic pressed;
  } key_pair_t;

  // Summary bits followed by every supported key
  typedef struct packed {
    logic      pressed;
    logic      released;
    key_pair_t q;
    key_pair_t w;
    key_pair_t e;
    key_pair_t a;
    key_pair_t s;
    key_pair_t d;
    key_pair_t u;
    key_pair_t j;
    key_pair_t i;
    key_pair_t k;
    key_pair_t o;
    key_pair_t l;
    key_pair_t n1;
    key_pair_t n2;
    key_pair_t n3;
    key_pair_t n4;
    key_pair_t n5;
    key_pair_t n6;
    key_pair_t n7;
    key_pair_t n8;
    key_pair_t n9;
    key_pair_t n0;
  } keys_t;

  // +1, 0 or -1
  typedef logic signed [1:0] axis_dir_t;

  typedef struct packed {
    axis_dir_t  trans_x;
    axis_dir_t  trans_y;
    axis_dir_t  trans_z;
    axis_dir_t  rot_x;
    axis_dir_t  rot_y;
    axis_dir_t  rot_z;
    logic [2:0] res_sel;
    logic [1:0] speed_sel;
  } cam_ctrl_t;

endpackage

/* hw/ps2_rx.sv */
`timescale 1ns/1ps
`include "ps2_config.svh"

module ps2_rx (
  input  logic       clk,
  input  logic       rst_b,
  input  logic       ps2_clk_i,
  input  logic       ps2_data_i,
  output logic [7:0] ps2_pkt_DH,
  output logic       rec_ps2_pkt,
  output logic       frame_err_o
);

  localparam int TMO_W = $clog2(`PS2_RX_TIMEOUT + 1);

  // Two sync stages plus a third clock stage for edge detection
  logic [2:0]       clk_sync;
  logic [1:0]       data_sync;
  logic             clk_fall;
  logic [10:0]      shift_q;
  logic [10:0]      frame;
  logic [3:0]       bit_cnt;
  logic [TMO_W-1:0] idle_cnt;
  logic             last_bit;
  logic             frame_ok;

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      clk_sync  <= 3'b111;
      data_sync <= 2'b11;
    end else begin
      clk_sync  <= {clk_sync[1:0], ps2_clk_i};
      data_sync <= {data_sync[0], ps2_data_i};
    end
  end

  assign clk_fall = clk_sync[2] & ~clk_sync[1];

  // Bits arrive LSB first, so new bits enter at the top
  assign frame    = {data_sync[1], shift_q[10:1]};
  assign last_bit = clk_fall && (bit_cnt == 4'd10);

  // Start low, odd parity over data and parity, stop high
  assign frame_ok = !frame[0] && (^frame[9:1]) && frame[10];

  always_ff @(posedge clk) begin
    if (clk_fall) begin
      shift_q <= frame;
    end
    if (last_bit) begin
      ps2_pkt_DH <= frame[8:1];
    end
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      bit_cnt  <= 4'd0;
      idle_cnt <= '0;
    end else if (clk_fall) begin
      idle_cnt <= '0;
      bit_cnt  <= last_bit ? 4'd0 : bit_cnt + 4'd1;
    end else if (bit_cnt != 4'd0) begin
      // Stalled frame is dropped
      if (idle_cnt == TMO_W'(`PS2_RX_TIMEOUT - 1)) begin
        bit_cnt  <= 4'd0;
        idle_cnt <= '0;
      end else begin
        idle_cnt <= idle_cnt + TMO_W'(1);
      end
    end
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      rec_ps2_pkt <= 1'b0;
      frame_err_o <= 1'b0;
    end else begin
      rec_ps2_pkt <= last_bit & frame_ok;
      frame_err_o <= last_bit & ~frame_ok;
    end
  end

endmodule

/* hw/ps2_parse.sv */
`timescale 1ns/1ps
`include "ps2_config.svh"

// Make codes arrive as XX or E0 XX
// Break codes arrive as F0 XX or E0 F0 XX
module ps2_parse (
  input  logic              clk,
  input  logic              rst_b,
  input  logic [7:0]        ps2_pkt_DH,
  input  logic              rec_ps2_pkt,
  output ps2_pkg::keys_t    keys
);

  typedef enum logic [1:0] {
    IDLE,
    E0,
    F0
  } state_t;

  state_t               state_q;
  state_t               state_d;
  logic                 ext_q;
  logic                 ext_d;
  logic                 is_ext;
  logic                 is_brk;
  logic                 prefix;
  logic                 final_byte;
  logic                 brk;
  logic                 hit;
  ps2_pkg::key_pair_t   pulse;
  ps2_pkg::keys_t       keys_d;

  assign is_ext = (ps2_pkt_DH == `PS2_EXT_CODE);
  assign is_brk = (ps2_pkt_DH == `PS2_BREAK_CODE);

  // After F0 every byte is final including a prefix value
  assign prefix     = (is_ext | is_brk) && (state_q != F0);
  assign final_byte = rec_ps2_pkt & ~prefix;
  assign brk        = (state_q == F0);

  always_comb begin
    state_d = state_q;
    ext_d   = ext_q;
    if (rec_ps2_pkt) begin
      if (final_byte) begin
        state_d = IDLE;
        ext_d   = 1'b0;
      end else if (is_brk) begin
        state_d = F0;
      end else begin
        state_d = E0;
        ext_d   = 1'b1;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      state_q <= IDLE;
      ext_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ext_q   <= ext_d;
    end
  end

  assign pulse.released = brk;
  assign pulse.pressed  = ~brk;

  // Decode extended flag and code into one key pair
  always_comb begin
    keys_d = '0;
    hit    = 1'b1;
    if (final_byte) begin
      case ({ext_q, ps2_pkt_DH})
        // Translation
        9'h015: keys_d.q = pulse;
        9'h01D: keys_d.w = pulse;
        9'h024: keys_d.e = pulse;
        9'h01C: keys_d.a = pulse;
        9'h01B: keys_d.s = pulse;
        9'h023: keys_d.d = pulse;
        // Rotation
        9'h03C: keys_d.u = pulse;
        9'h03B: keys_d.j = pulse;
        9'h043: keys_d.i = pulse;
        9'h042: keys_d.k = pulse;
        9'h044: keys_d.o = pulse;
        9'h04B: keys_d.l = pulse;
        // Resolution select
        9'h016: keys_d.n1 = pulse;
        9'h01E: keys_d.n2 = pulse;
        9'h026: keys_d.n3 = pulse;
        9'h025: keys_d.n4 = pulse;
        9'h02E: keys_d.n5 = pulse;
        9'h036: keys_d.n6 = pulse;
        // Speed select
        9'h03D: keys_d.n7 = pulse;
        9'h03E: keys_d.n8 = pulse;
        9'h046: keys_d.n9 = pulse;
        9'h045: keys_d.n0 = pulse;
        default: hit = 1'b0;
      endcase
      if (hit) begin
        keys_d.pressed  = ~brk;
        keys_d.released = brk;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      keys <= '0;
    end else begin
      keys <= keys_d;
    end
  end

endmodule

/* hw/key_state.sv */
`timescale 1ns/1ps
`include "ps2_config.svh"

module key_state (
  input  logic                  clk,
  input  logic                  rst_b,
  input  ps2_pkg::keys_t        keys_i,
  output ps2_pkg::cam_ctrl_t    cam_o
);

  // Levels of the twelve motion keys
  typedef struct packed {
    logic d;
    logic a;
    logic w;
    logic s;
    logic e;
    logic q;
    logic i;
    logic k;
    logic u;
    logic j;
    logic o;
    logic l;
  } held_t;

  localparam ps2_pkg::cam_ctrl_t CAM_RESET = '{
    speed_sel: 2'(`PS2_SPEED_RESET),
    default:   '0
  };

  held_t              held_q;
  held_t              held_d;
  ps2_pkg::cam_ctrl_t cam_d;

  function automatic logic hold_next(logic cur, ps2_pkg::key_pair_t kp);
    return kp.pressed | (cur & ~kp.released);
  endfunction

  // Both or neither held gives 0
  function automatic ps2_pkg::axis_dir_t axis_dir(logic pos, logic neg);
    case ({pos, neg})
      2'b10:   return 2'sd1;
      2'b01:   return -2'sd1;
      default: return 2'sd0;
    endcase
  endfunction

  always_comb begin
    held_d.d = hold_next(held_q.d, keys_i.d);
    held_d.a = hold_next(held_q.a, keys_i.a);
    held_d.w = hold_next(held_q.w, keys_i.w);
    held_d.s = hold_next(held_q.s, keys_i.s);
    held_d.e = hold_next(held_q.e, keys_i.e);
    held_d.q = hold_next(held_q.q, keys_i.q);
    held_d.i = hold_next(held_q.i, keys_i.i);
    held_d.k = hold_next(held_q.k, keys_i.k);
    held_d.u = hold_next(held_q.u, keys_i.u);
    held_d.j = hold_next(held_q.j, keys_i.j);
    held_d.o = hold_next(held_q.o, keys_i.o);
    held_d.l = hold_next(held_q.l, keys_i.l);
  end

  always_comb begin
    cam_d         = cam_o;
    cam_d.trans_x = axis_dir(held_d.d, held_d.a);
    cam_d.trans_y = axis_dir(held_d.w, held_d.s);
    cam_d.trans_z = axis_dir(held_d.e, held_d.q);
    cam_d.rot_x   = axis_dir(held_d.i, held_d.k);
    cam_d.rot_y   = axis_dir(held_d.u, held_d.j);
    cam_d.rot_z   = axis_dir(held_d.o, held_d.l);
    // Selectors latch on press only
    if (keys_i.n1.pressed) cam_d.res_sel = 3'd0;
    else if (keys_i.n2.pressed) cam_d.res_sel = 3'd1;
    else if (keys_i.n3.pressed) cam_d.res_sel = 3'd2;
    else if (keys_i.n4.pressed) cam_d.res_sel = 3'd3;
    else if (keys_i.n5.pressed) cam_d.res_sel = 3'd4;
    else if (keys_i.n6.pressed) cam_d.res_sel = 3'd5;
    if (keys_i.n7.pressed) cam_d.speed_sel = 2'd0;
    else if (keys_i.n8.pressed) cam_d.speed_sel = 2'd1;
    else if (keys_i.n9.pressed) cam_d.speed_sel = 2'd2;
    else if (keys_i.n0.pressed) cam_d.speed_sel = 2'd3;
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      held_q <= '0;
      cam_o  <= CAM_RESET;
    end else begin
      held_q <= held_d;
      cam_o  <= cam_d;
    end
  end

endmodule

/* hw/ps2_keyboard.sv */
`timescale 1ns/1ps

module ps2_keyboard (
  input  logic                  clk,
  input  logic                  rst_b,
  input  logic                  ps2_clk_i,
  input  logic                  ps2_data_i,
  output ps2_pkg::cam_ctrl_t    cam_o,
  output logic                  frame_err_o
);

  logic [7:0]     ps2_pkt_DH;
  logic           rec_ps2_pkt;
  ps2_pkg::keys_t keys;

  // Serial lines to bytes
  ps2_rx i_ps2_rx (
    .clk         (clk),
    .rst_b       (rst_b),
    .ps2_clk_i   (ps2_clk_i),
    .ps2_data_i  (ps2_data_i),
    .ps2_pkt_DH  (ps2_pkt_DH),
    .rec_ps2_pkt (rec_ps2_pkt),
    .frame_err_o (frame_err_o)
  );

  // Bytes to key pulses
  ps2_parse i_ps2_parse (
    .clk         (clk),
    .rst_b       (rst_b),
    .ps2_pkt_DH  (ps2_pkt_DH),
    .rec_ps2_pkt (rec_ps2_pkt),
    .keys        (keys)
  );

  // Key pulses to camera commands
  key_state i_key_state (
    .clk    (clk),
    .rst_b  (rst_b),
    .keys_i (keys),
    .cam_o  (cam_o)
  );

endmodule

/* test/ps2_tb_clk.sv */
`timescale 1ns/1ps

// Free running 4 ns clock
module ps2_tb_clk (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

endmodule

/* test/ps2_tb.sv */
`timescale 1ns/1ps
`include "ps2_config.svh"

module ps2_tb;

  // Set 2 make codes in key order q w e a s d u j i k o l 1 2 3 4 5 6 7 8 9 0
  localparam logic [7:0] KEY_CODE [22] = '{
    8'h15, 8'h1D, 8'h24, 8'h1C, 8'h1B, 8'h23, 8'h3C, 8'h3B, 8'h43, 8'h42, 8'h44,
    8'h4B, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45
  };

  logic               clk;
  logic               rst_b;
  logic               ps2_clk;
  logic               ps2_data;
  ps2_pkg::cam_ctrl_t cam_o;
  logic               frame_err_o;

  // Reference model state
  ps2_pkg::cam_ctrl_t exp_cam;
  logic [11:0]        held;
  logic               m_ext;
  logic               m_brk;

  int err_cnt = 0;
  int checks = 0;
  int tests = 0;
  int errs_at_start = 0;
  int err_pulses = 0;
  int seed = 32'hdc281b1e;

  ps2_tb_clk i_ps2_tb_clk (
    .clk_o (clk)
  );

  ps2_keyboard i_ps2_keyboard (
    .clk         (clk),
    .rst_b       (rst_b),
    .ps2_clk_i   (ps2_clk),
    .ps2_data_i  (ps2_data),
    .cam_o       (cam_o),
    .frame_err_o (frame_err_o)
  );

  // Count error pulses between edges
  always @(negedge clk) begin
    if (frame_err_o) begin
      err_pulses <= err_pulses + 1;
    end
  end

  function automatic int key_index(input logic [7:0] code);
    for (int n = 0; n < 22; n++) begin
      if (KEY_CODE[5'(n)] == code) begin
        return n;
      end
    end
    return -1;
  endfunction

  function automatic ps2_pkg::axis_dir_t axis_of(input logic pos, input logic neg);
    return (pos == neg) ? 2'b00 : (pos ? 2'b01 : 2'b11);
  endfunction

  // Expected camera command after one final byte
  function automatic ps2_pkg::cam_ctrl_t ref_cam(input ps2_pkg::cam_ctrl_t cur,
                                                 input logic [11:0] held_in,
                                                 input logic ext, input logic brk,
                                                 input logic [7:0] code,
                                                 output logic [11:0] held_out);
    ps2_pkg::cam_ctrl_t nxt;
    int idx;
    nxt      = cur;
    held_out = held_in;
    idx      = ext ? -1 : key_index(code);
    if (idx >= 0 && idx < 12) begin
      held_out[4'(idx)] = !brk;
    end else if (idx >= 12 && idx < 18 && !brk) begin
      nxt.res_sel = 3'(idx - 12);
    end else if (idx >= 18 && !brk) begin
      nxt.speed_sel = 2'(idx - 18);
    end
    nxt.trans_x = axis_of(held_out[5], held_out[3]);
    nxt.trans_y = axis_of(held_out[1], held_out[4]);
    nxt.trans_z = axis_of(held_out[2], held_out[0]);
    nxt.rot_x   = axis_of(held_out[8], held_out[9]);
    nxt.rot_y   = axis_of(held_out[6], held_out[7]);
    nxt.rot_z   = axis_of(held_out[10], held_out[11]);
    return nxt;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s done, %0d errors", name, err_cnt - errs_at_start);
    errs_at_start = err_cnt;
  endtask

  // Frame of start, 8 data bits LSB first, odd parity and stop
  // Each bit takes 16 clk cycles
  task automatic send_byte(input logic [7:0] b, input logic bad_par);
    logic [10:0] frame;
    frame = {1'b1, (~^b) ^ bad_par, b, 1'b0};
    for (int n = 0; n < 11; n++) begin
      @(posedge clk);
      ps2_data <= frame[0];
      frame = frame >> 1;
      repeat (4) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (8) @(posedge clk);
      ps2_clk <= 1'b1;
      repeat (3) @(posedge clk);
    end
    @(posedge clk);
    ps2_data <= 1'b1;
    repeat (8) @(posedge clk);
  endtask

  task automatic wait_cam(input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (cam_o !== exp_cam && n < 20) begin
      @(negedge clk);
      n++;
    end
    check_val(what, 32'(cam_o), 32'(exp_cam));
  endtask

  // Sends one byte, advances the model and checks final bytes
  task automatic put_byte(input logic [7:0] b);
    logic [11:0] held_n;
    send_byte(b, 1'b0);
    if (!m_brk && b == `PS2_EXT_CODE) begin
      m_ext = 1'b1;
    end else if (!m_brk && b == `PS2_BREAK_CODE) begin
      m_brk = 1'b1;
    end else begin
      exp_cam = ref_cam(exp_cam, held, m_ext, m_brk, b, held_n);
      held    = held_n;
      m_ext   = 1'b0;
      m_brk   = 1'b0;
      wait_cam($sformatf("cam_o after byte %h", b));
    end
  endtask

  task automatic make_key(input logic [7:0] code);
    put_byte(code);
  endtask

  task automatic break_key(input logic [7:0] code);
    put_byte(`PS2_BREAK_CODE);
    put_byte(code);
  endtask

  initial begin
    int pulses0;
    int n;
    logic [31:0] r;
    rst_b    = 1'b0;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    exp_cam  = '{speed_sel: 2'(`PS2_SPEED_RESET), default: '0};
    held     = '0;
    m_ext    = 1'b0;
    m_brk    = 1'b0;
    repeat (5) @(posedge clk);
    rst_b <= 1'b1;

    repeat (4) @(negedge clk);
    check_val("cam_o after reset", 32'(cam_o), 32'(exp_cam));
    check_val("frame_err_o pulses after reset", err_pulses, 0);
    finish_test("reset");

    // d and a share trans_x
    make_key(8'h23);
    make_key(8'h1C);
    break_key(8'h23);
    break_key(8'h1C);
    make_key(8'h1D);
    make_key(8'h1B);
    break_key(8'h1B);
    break_key(8'h1D);
    make_key(8'h24);
    make_key(8'h15);
    break_key(8'h24);
    break_key(8'h15);
    finish_test("axis directions");

    // E0 1D must not press w, E0 F0 1D must not release it
    put_byte(`PS2_EXT_CODE);
    put_byte(8'h1D);
    make_key(8'h1D);
    put_byte(`PS2_EXT_CODE);
    put_byte(`PS2_BREAK_CODE);
    put_byte(8'h1D);
    break_key(8'h1D);
    finish_test("extended prefix");

    make_key(8'h26);
    make_key(8'h3E);
    break_key(8'h26);
    break_key(8'h3E);
    make_key(8'h36);
    make_key(8'h45);
    break_key(8'h36);
    finish_test("latched selectors");

    check_val("frame_err_o pulses on good frames", err_pulses, 0);
    pulses0 = err_pulses;
    send_byte(8'h1C, 1'b1);
    n = 0;
    while (err_pulses == pulses0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (err_pulses == pulses0) begin
      err_cnt++;
      $display("Bad parity frame produced no frame_err_o pulse within 20 cycles");
    end
    check_val("frame_err_o pulse count", err_pulses - pulses0, 1);
    wait_cam("cam_o after bad frame");
    make_key(8'h1C);
    break_key(8'h1C);
    finish_test("error handling");

    // Prefixes, then a key code or an unknown byte
    for (int s = 0; s < 200; s++) begin
      r = $random(seed);
      if (r[2:0] == 3'd0) begin
        put_byte(`PS2_EXT_CODE);
      end
      if (r[3]) begin
        put_byte(`PS2_BREAK_CODE);
      end
      if (r[5:4] == 2'd0) begin
        put_byte({1'b0, r[14:8]});
      end else begin
        put_byte(KEY_CODE[5'(int'(r[20:16]) % 22)]);
      end
    end
    finish_test("random stress");

    $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/ps2_pkg.sv
hw/ps2_rx.sv
hw/ps2_parse.sv
hw/key_state.sv
hw/ps2_keyboard.sv
test/ps2_tb_clk.sv
test/ps2_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --timing
TOP      = ps2_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the log holds the pass message
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
